/* kmac_params.svh */
// KMAC widths, depths and timing constants
// Shared by the message path, the key block and the absorb engine

`ifndef KMAC_PARAMS_SVH
`define KMAC_PARAMS_SVH

// Message and lane word width
`define KMAC_WORD_W 32

// Message FIFO entries and the width of its fill count
`define KMAC_FIFO_DEPTH 8
`define KMAC_DEPTH_W 4

// Sponge geometry
`define KMAC_RATE_WORDS 4
`define KMAC_KEY_WORDS 2

// Round cycles spent on every block
`define KMAC_ROUNDS 24

`endif

/* kmac_cmd_pkg.sv */
// KMAC command types
// Software commands, error codes and the control FSM states

`default_nettype none

package kmac_cmd_pkg;

  // Software commands
  typedef enum logic [1:0] {
    CmdNone    = 2'd0,
    CmdStart   = 2'd1,
    CmdProcess = 2'd2,
    CmdDone    = 2'd3
  } kmac_cmd_e;

  // Error codes reported on err_code_o
  typedef enum logic [7:0] {
    ErrNone          = 8'h00,
    ErrSwCmdSequence = 8'h01
  } kmac_err_e;

  // Control FSM, plain binary
  typedef enum logic [1:0] {
    KmacIdle     = 2'd0,
    KmacKeyBlock = 2'd1,
    KmacMsgFeed  = 2'd2,
    KmacDigest   = 2'd3
  } kmac_st_e;

endpackage

`default_nettype wire

/* sha3_pkg.sv */
// SHA3 absorb engine types
// Engine phase and the rate lane index

`default_nettype none

package sha3_pkg;

  // Sponge phase as seen by the controller
  typedef enum logic [1:0] {
    StIdle    = 2'd0,
    StAbsorb  = 2'd1,
    StSqueeze = 2'd2
  } sha3_phase_e;

  // Index into the rate lanes, four lanes
  typedef logic [1:0] lane_idx_t;

endpackage

`default_nettype wire

/* kmac_msgfifo.sv */
// Message FIFO
// Circular buffer between the host and the KMAC core, one credit back per
// word read, Process forwarded once the buffer has drained

`default_nettype none

`include "kmac_params.svh"

module kmac_msgfifo (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     wr_valid_i,
  input  logic [`KMAC_WORD_W-1:0]  wr_data_i,
  input  logic                     rd_ready_i,
  input  logic                     process_i,
  input  logic                     clear_i,
  output logic                     rd_valid_o,
  output logic [`KMAC_WORD_W-1:0]  rd_data_o,
  output logic                     credit_o,
  output logic                     empty_o,
  output logic [`KMAC_DEPTH_W-1:0] depth_o,
  output logic                     process_o
);

  localparam int DepthW = `KMAC_DEPTH_W;
  localparam int PtrW   = $clog2(`KMAC_FIFO_DEPTH);

  logic [`KMAC_WORD_W-1:0] mem_q [`KMAC_FIFO_DEPTH];
  logic [PtrW-1:0]         wr_ptr_q, rd_ptr_q;
  logic [DepthW-1:0]       depth_q;
  logic                    rd_hs;
  logic                    pend_q;

  // Host honours its credits, so a write is never refused
  assign rd_hs      = rd_valid_o & rd_ready_i;
  assign rd_valid_o = (depth_q != '0);
  assign rd_data_o  = mem_q[rd_ptr_q];
  assign empty_o    = (depth_q == '0);
  assign depth_o    = depth_q;

  // Credit goes back as the core takes the word
  assign credit_o = rd_hs;

  // Process leaves only behind the last word
  assign process_o = pend_q & empty_o;

  always_ff @(posedge clk_i) begin
    if (wr_valid_i) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      depth_q  <= '0;
      pend_q   <= 1'b0;
    end else begin
      if (wr_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_hs) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      depth_q <= depth_q + DepthW'(wr_valid_i) - DepthW'(rd_hs);

      // Pending Process, dropped on Done
      if (clear_i || process_o) begin
        pend_q <= 1'b0;
      end else if (process_i) begin
        pend_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* kmac_core.sv */
// KMAC core
// Holds the secret key and sends the zero-padded key block to the engine
// ahead of the message words when KMAC is enabled

`default_nettype none

`include "kmac_params.svh"

module kmac_core
  import sha3_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 start_i,
  input  logic                                 kmac_en_i,
  input  logic                                 key_we_i,
  input  logic [$clog2(`KMAC_KEY_WORDS)-1:0]   key_idx_i,
  input  logic [`KMAC_WORD_W-1:0]              key_word_i,
  input  logic                                 fifo_valid_i,
  input  logic [`KMAC_WORD_W-1:0]              fifo_data_i,
  input  logic                                 msg_ready_i,
  input  logic                                 process_i,
  output logic                                 fifo_ready_o,
  output logic                                 msg_valid_o,
  output logic [`KMAC_WORD_W-1:0]              msg_data_o,
  output logic                                 process_o
);

  localparam int        KeyIdxW  = $clog2(`KMAC_KEY_WORDS);
  localparam lane_idx_t LastWord = lane_idx_t'(`KMAC_RATE_WORDS - 1);

  logic [`KMAC_WORD_W-1:0] key_q [`KMAC_KEY_WORDS];
  logic                    started_q;
  logic                    kb_active_q;
  lane_idx_t               cnt_q;
  logic                    pend_q;
  logic                    kb_hs;
  logic [`KMAC_WORD_W-1:0] kb_word;

  // Key words first, zeros for the rest of the block
  assign kb_word = (cnt_q < lane_idx_t'(`KMAC_KEY_WORDS)) ? key_q[cnt_q[KeyIdxW-1:0]] : '0;
  assign kb_hs   = kb_active_q & msg_ready_i;

  // Valid/ready mux, key block has priority
  assign msg_valid_o  = kb_active_q | fifo_valid_i;
  assign msg_data_o   = kb_active_q ? kb_word : fifo_data_i;
  assign fifo_ready_o = ~kb_active_q & msg_ready_i;

  // Process waits until the key block has left
  assign process_o = (process_i | pend_q) & ~kb_active_q;

  // Key registers, locked during an operation
  always_ff @(posedge clk_i) begin
    if (key_we_i && !started_q) begin
      key_q[key_idx_i] <= key_word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q   <= 1'b0;
      kb_active_q <= 1'b0;
      cnt_q       <= '0;
      pend_q      <= 1'b0;
    end else begin
      if (start_i) begin
        started_q <= 1'b1;
      end else if (process_o) begin
        started_q <= 1'b0;
      end

      if (start_i && kmac_en_i) begin
        kb_active_q <= 1'b1;
        cnt_q       <= '0;
      end else if (kb_hs) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == LastWord) begin
          kb_active_q <= 1'b0;
        end
      end

      pend_q <= (process_i | pend_q) & kb_active_q;
    end
  end

endmodule

`default_nettype wire

/* sha3_absorb.sv */
// SHA3 absorb engine
// XORs words into the rate lanes, times the rounds of each block, pads the
// final block and exposes the lanes in the squeeze phase

`default_nettype none

`include "kmac_params.svh"

module sha3_absorb
  import sha3_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  logic                    msg_valid_i,
  input  logic [`KMAC_WORD_W-1:0] msg_data_i,
  input  logic                    process_i,
  input  logic                    done_i,
  input  lane_idx_t               state_idx_i,
  output logic                    msg_ready_o,
  output logic                    block_processed_o,
  output logic                    absorbed_o,
  output sha3_phase_e             phase_o,
  output logic [`KMAC_WORD_W-1:0] state_o
);

  localparam int        WordW    = `KMAC_WORD_W;
  localparam int        RndW     = $clog2(`KMAC_ROUNDS);
  localparam lane_idx_t LastLane = lane_idx_t'(`KMAC_RATE_WORDS - 1);

  logic [WordW-1:0] state_q [`KMAC_RATE_WORDS];
  logic [WordW-1:0] pad_vec [`KMAC_RATE_WORDS];
  sha3_phase_e      phase_q;
  lane_idx_t        lane_ptr_q;
  logic [RndW-1:0]  round_q;
  logic             busy_q, final_q, pend_q;
  logic             blk_q, abs_q;
  logic             msg_hs, pad_req;

  // No new words while rounds run, the final pad is always under rounds
  assign msg_ready_o = (phase_q == StAbsorb) & ~busy_q;
  assign msg_hs      = msg_valid_i & msg_ready_o;
  assign pad_req     = (process_i | pend_q) & ~busy_q & (phase_q == StAbsorb);

  assign block_processed_o = blk_q;
  assign absorbed_o        = abs_q;
  assign phase_o           = phase_q;
  assign state_o           = (phase_q == StSqueeze) ? state_q[state_idx_i] : '0;

  // Padding: 6 into the next lane, top bit into the last lane
  always_comb begin
    for (int i = 0; i < `KMAC_RATE_WORDS; i++) begin
      pad_vec[i] = '0;
      if (lane_idx_t'(i) == lane_ptr_q) begin
        pad_vec[i] = pad_vec[i] ^ WordW'(6);
      end
      if (i == `KMAC_RATE_WORDS - 1) begin
        pad_vec[i] = pad_vec[i] ^ {1'b1, {(WordW-1){1'b0}}};
      end
    end
  end

  // Lane state, rounds leave it unchanged
  always_ff @(posedge clk_i) begin
    if (start_i || done_i) begin
      state_q <= '{default: '0};
    end else if (pad_req) begin
      for (int i = 0; i < `KMAC_RATE_WORDS; i++) begin
        state_q[i] <= state_q[i] ^ pad_vec[i];
      end
    end else if (msg_hs) begin
      state_q[lane_ptr_q] <= state_q[lane_ptr_q] ^ msg_data_i;
    end
  end

  //////////////////////////////////////////////////
  // Phase, lane pointer and round timer
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q    <= StIdle;
      lane_ptr_q <= '0;
      round_q    <= '0;
      busy_q     <= 1'b0;
      final_q    <= 1'b0;
      pend_q     <= 1'b0;
      blk_q      <= 1'b0;
      abs_q      <= 1'b0;
    end else begin
      blk_q <= 1'b0;
      abs_q <= 1'b0;
      if (done_i) begin
        phase_q    <= StIdle;
        lane_ptr_q <= '0;
        round_q    <= '0;
        busy_q     <= 1'b0;
        final_q    <= 1'b0;
        pend_q     <= 1'b0;
      end else if (start_i) begin
        phase_q    <= StAbsorb;
        lane_ptr_q <= '0;
      end else if (busy_q) begin
        // Process arriving mid-rounds waits here
        pend_q <= pend_q | process_i;
        if (round_q == RndW'(`KMAC_ROUNDS - 1)) begin
          busy_q  <= 1'b0;
          round_q <= '0;
          if (final_q) begin
            final_q <= 1'b0;
            abs_q   <= 1'b1;
            phase_q <= StSqueeze;
          end else begin
            blk_q <= 1'b1;
          end
        end else begin
          round_q <= round_q + 1'b1;
        end
      end else if (pad_req) begin
        pend_q     <= 1'b0;
        final_q    <= 1'b1;
        busy_q     <= 1'b1;
        lane_ptr_q <= '0;
      end else if (msg_hs) begin
        lane_ptr_q <= lane_ptr_q + 1'b1;
        // Block full
        if (lane_ptr_q == LastLane) begin
          busy_q <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* kmac_ctrl.sv */
// KMAC control
// Checks the command sequence, runs the control FSM, raises the sticky
// interrupts and keeps the error code and the idle flag

`default_nettype none

module kmac_ctrl
  import kmac_cmd_pkg::*;
  import sha3_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cmd_valid_i,
  input  kmac_cmd_e   cmd_i,
  input  logic        kmac_en_i,
  input  logic        block_processed_i,
  input  logic        absorbed_i,
  input  logic        fifo_empty_i,
  input  sha3_phase_e phase_i,
  input  logic [2:0]  intr_clear_i,
  output logic        start_o,
  output logic        process_o,
  output logic        done_o,
  output logic        intr_done_o,
  output logic        intr_fifo_empty_o,
  output logic        intr_err_o,
  output logic        err_valid_o,
  output kmac_err_e   err_code_o,
  output kmac_cmd_e   err_info_o,
  output logic        idle_o
);

  kmac_st_e   st_q, st_d;
  logic       proc_q;
  logic       legal, bad_cmd;
  logic       empty_q, empty_evt;
  logic [2:0] intr_q, intr_evt;

  //////////////////////////////////////////////////
  // Command check
  //////////////////////////////////////////////////
  always_comb begin
    unique case (cmd_i)
      CmdStart:   legal = (st_q == KmacIdle);
      CmdProcess: legal = (st_q == KmacMsgFeed) & ~proc_q;
      CmdDone:    legal = (st_q == KmacDigest);
      default:    legal = 1'b1;
    endcase
  end

  assign bad_cmd   = cmd_valid_i & ~legal;
  assign start_o   = cmd_valid_i & legal & (cmd_i == CmdStart);
  assign process_o = cmd_valid_i & legal & (cmd_i == CmdProcess);
  assign done_o    = cmd_valid_i & legal & (cmd_i == CmdDone);

  // Control FSM
  always_comb begin
    st_d = st_q;
    unique case (st_q)
      KmacIdle: begin
        if (start_o) begin
          st_d = kmac_en_i ? KmacKeyBlock : KmacMsgFeed;
        end
      end
      KmacKeyBlock: begin
        if (block_processed_i) begin
          st_d = KmacMsgFeed;
        end
      end
      KmacMsgFeed: begin
        if (absorbed_i) begin
          st_d = KmacDigest;
        end
      end
      KmacDigest: begin
        if (done_o) begin
          st_d = KmacIdle;
        end
      end
      default: st_d = KmacIdle;
    endcase
  end

  // FIFO went from holding words to empty
  assign empty_evt = ~empty_q & fifo_empty_i;

  // Interrupt events, bit order done, FIFO empty, error
  assign intr_evt = {bad_cmd, empty_evt, absorbed_i};

  assign intr_done_o       = intr_q[0];
  assign intr_fifo_empty_o = intr_q[1];
  assign intr_err_o        = intr_q[2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q        <= KmacIdle;
      proc_q      <= 1'b0;
      empty_q     <= 1'b1;
      intr_q      <= '0;
      err_valid_o <= 1'b0;
      err_code_o  <= ErrNone;
      err_info_o  <= CmdNone;
      idle_o      <= 1'b1;
    end else begin
      st_q    <= st_d;
      empty_q <= fifo_empty_i;

      // One Process per message
      if (st_d != KmacMsgFeed) begin
        proc_q <= 1'b0;
      end else if (process_o) begin
        proc_q <= 1'b1;
      end

      // Sticky, a new event beats a clear
      intr_q <= (intr_q & ~intr_clear_i) | intr_evt;

      // Dropped command
      err_valid_o <= bad_cmd;
      if (bad_cmd) begin
        err_code_o <= ErrSwCmdSequence;
        err_info_o <= cmd_i;
      end

      idle_o <= (phase_i == StIdle) & fifo_empty_i;
    end
  end

endmodule

`default_nettype wire

/* kmac_top.sv */
// KMAC top level
// Message FIFO, key block insertion, absorb engine and control

`default_nettype none

`include "kmac_params.svh"

module kmac_top
  import kmac_cmd_pkg::*;
  import sha3_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               cmd_valid_i,
  input  kmac_cmd_e                          cmd_i,
  input  logic                               kmac_en_i,
  input  logic                               key_we_i,
  input  logic [$clog2(`KMAC_KEY_WORDS)-1:0] key_idx_i,
  input  logic [`KMAC_WORD_W-1:0]            key_word_i,
  input  logic                               msg_valid_i,
  input  logic [`KMAC_WORD_W-1:0]            msg_data_i,
  output logic                               msg_credit_o,
  output logic [`KMAC_DEPTH_W-1:0]           fifo_depth_o,
  output sha3_phase_e                        phase_o,
  input  lane_idx_t                          state_idx_i,
  output logic [`KMAC_WORD_W-1:0]            state_o,
  output logic                               intr_done_o,
  output logic                               intr_fifo_empty_o,
  output logic                               intr_err_o,
  input  logic [2:0]                         intr_clear_i,
  output logic                               err_valid_o,
  output kmac_err_e                          err_code_o,
  output kmac_cmd_e                          err_info_o,
  output logic                               idle_o
);

  // Commands from the control block
  logic start, ctrl_process, done;

  // FIFO to core
  logic                    fifo_valid, fifo_ready, fifo_empty, fifo_process;
  logic [`KMAC_WORD_W-1:0] fifo_data;

  // Core to engine
  logic                    msg_valid, msg_ready, core_process;
  logic [`KMAC_WORD_W-1:0] msg_data;

  // Engine status
  logic block_processed, absorbed;

  kmac_msgfifo i_kmac_msgfifo (
    .clk_i,
    .rst_ni,
    .wr_valid_i (msg_valid_i),
    .wr_data_i  (msg_data_i),
    .rd_ready_i (fifo_ready),
    .process_i  (ctrl_process),
    .clear_i    (done),
    .rd_valid_o (fifo_valid),
    .rd_data_o  (fifo_data),
    .credit_o   (msg_credit_o),
    .empty_o    (fifo_empty),
    .depth_o    (fifo_depth_o),
    .process_o  (fifo_process)
  );

  kmac_core i_kmac_core (
    .clk_i,
    .rst_ni,
    .start_i      (start),
    .kmac_en_i,
    .key_we_i,
    .key_idx_i,
    .key_word_i,
    .fifo_valid_i (fifo_valid),
    .fifo_data_i  (fifo_data),
    .msg_ready_i  (msg_ready),
    .process_i    (fifo_process),
    .fifo_ready_o (fifo_ready),
    .msg_valid_o  (msg_valid),
    .msg_data_o   (msg_data),
    .process_o    (core_process)
  );

  sha3_absorb i_sha3_absorb (
    .clk_i,
    .rst_ni,
    .start_i           (start),
    .msg_valid_i       (msg_valid),
    .msg_data_i        (msg_data),
    .process_i         (core_process),
    .done_i            (done),
    .state_idx_i,
    .msg_ready_o       (msg_ready),
    .block_processed_o (block_processed),
    .absorbed_o        (absorbed),
    .phase_o,
    .state_o
  );

  kmac_ctrl i_kmac_ctrl (
    .clk_i,
    .rst_ni,
    .cmd_valid_i,
    .cmd_i,
    .kmac_en_i,
    .block_processed_i (block_processed),
    .absorbed_i        (absorbed),
    .fifo_empty_i      (fifo_empty),
    .phase_i           (phase_o),
    .intr_clear_i,
    .start_o           (start),
    .process_o         (ctrl_process),
    .done_o            (done),
    .intr_done_o,
    .intr_fifo_empty_o,
    .intr_err_o,
    .err_valid_o,
    .err_code_o,
    .err_info_o,
    .idle_o
  );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// Testbench clock source
// Free-running clock with a period of 4 time units

`default_nettype none

module tb_clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // Half period of 2
  always #2 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* kmac_assert.sv */
// KMAC protocol checks
// Bound to the top level, watches the credit loop, the FIFO fill level
// and the lane readout

`default_nettype none

`include "kmac_params.svh"

module kmac_assert
  import sha3_pkg::*;
(
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     msg_valid_i,
  input logic                     msg_credit_i,
  input logic [`KMAC_DEPTH_W-1:0] fifo_depth_i,
  input sha3_phase_e              phase_i,
  input lane_idx_t                state_idx_i,
  input logic [`KMAC_WORD_W-1:0]  state_i
);

  // Running totals of host writes and returned credits
  int unsigned writes_q;
  int unsigned credits_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      writes_q  <= '0;
      credits_q <= '0;
    end else begin
      writes_q  <= writes_q + 32'(msg_valid_i);
      credits_q <= credits_q + 32'(msg_credit_i);
    end
  end

  //////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////

  // A credit needs a word written in an earlier cycle
  credit_after_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (credits_q + 32'(msg_credit_i)) <= writes_q)
    else $error("credit returned without a matching write");

  fifo_depth_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo_depth_i <= `KMAC_DEPTH_W'(`KMAC_FIFO_DEPTH))
    else $error("FIFO fill level above its depth");

  // Lanes hold still while squeezing at a fixed index
  lanes_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (phase_i == StSqueeze && $past(phase_i) == StSqueeze && $stable(state_idx_i))
    |-> $stable(state_i))
    else $error("lane data changed during the squeeze phase");

endmodule

bind kmac_top kmac_assert i_kmac_assert (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .msg_valid_i  (msg_valid_i),
  .msg_credit_i (msg_credit_o),
  .fifo_depth_i (fifo_depth_o),
  .phase_i      (phase_o),
  .state_idx_i  (state_idx_i),
  .state_i      (state_o)
);

`default_nettype wire

/* kmac_tb.sv */
// KMAC testbench
// Runs the operations of the pattern file against the top level and checks
// the lanes against a sponge model that has no permutation

`default_nettype none

`include "kmac_params.svh"

module kmac_tb
  import kmac_cmd_pkg::*;
  import sha3_pkg::*;
();

  localparam int WordW = `KMAC_WORD_W;
  localparam int Lanes = `KMAC_RATE_WORDS;
  localparam int KeyW  = $clog2(`KMAC_KEY_WORDS);

  logic                     clk_i;
  logic                     rst_ni;
  logic                     cmd_valid_i;
  kmac_cmd_e                cmd_i;
  logic                     kmac_en_i;
  logic                     key_we_i;
  logic [KeyW-1:0]          key_idx_i;
  logic [WordW-1:0]         key_word_i;
  logic                     msg_valid_i;
  logic [WordW-1:0]         msg_data_i;
  logic                     msg_credit_o;
  logic [`KMAC_DEPTH_W-1:0] fifo_depth_o;
  sha3_phase_e              phase_o;
  lane_idx_t                state_idx_i;
  logic [WordW-1:0]         state_o;
  logic                     intr_done_o;
  logic                     intr_fifo_empty_o;
  logic                     intr_err_o;
  logic [2:0]               intr_clear_i;
  logic                     err_valid_o;
  kmac_err_e                err_code_o;
  kmac_cmd_e                err_info_o;
  logic                     idle_o;

  // Sponge model and host bookkeeping
  logic [WordW-1:0] model_lane [Lanes];
  logic [WordW-1:0] model_key [`KMAC_KEY_WORDS];
  int               model_ptr;
  int               credits;
  int               credit_total;
  int               words_sent;
  int               cycles;
  int               cycle_limit;
  string            ops [$];

  tb_clk_gen i_tb_clk_gen (
    .clk_o (clk_i)
  );

  kmac_top i_kmac_top (.*);

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [WordW-1:0] got,
                             input logic [WordW-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // Cycle step, sampling and pulse release
  //////////////////////////////////////////////////
  task automatic tick();
    @(negedge clk_i);
    cycles++;
    if (cycles > cycle_limit) begin
      fail_run($sformatf("Timeout, DUT stalled after %0d cycles", cycles));
    end
    if (msg_credit_o) begin
      credits++;
      credit_total++;
    end
    if (fifo_depth_o > `KMAC_DEPTH_W'(`KMAC_FIFO_DEPTH)) begin
      fail_run($sformatf("ERROR fifo_depth_o 0x%h above 0x%h", fifo_depth_o,
                         `KMAC_FIFO_DEPTH));
    end
    // Single-cycle strobes
    cmd_valid_i  = 1'b0;
    key_we_i     = 1'b0;
    msg_valid_i  = 1'b0;
    intr_clear_i = '0;
  endtask

  task automatic model_clear();
    for (int i = 0; i < Lanes; i++) begin
      model_lane[i] = '0;
    end
    model_ptr = 0;
  endtask

  task automatic model_absorb(input logic [WordW-1:0] w);
    model_lane[model_ptr] ^= w;
    model_ptr = (model_ptr + 1) % Lanes;
  endtask

  // Host side, only sends with a credit in hand
  task automatic send_word(input logic [WordW-1:0] w);
    while (credits == 0) begin
      tick();
    end
    msg_valid_i = 1'b1;
    msg_data_i  = w;
    credits--;
    words_sent++;
    model_absorb(w);
    tick();
  endtask

  task automatic issue_cmd(input kmac_cmd_e c);
    cmd_valid_i = 1'b1;
    cmd_i       = c;
    tick();
  endtask

  task automatic check_lanes();
    for (int i = 0; i < Lanes; i++) begin
      state_idx_i = lane_idx_t'(i);
      tick();
      check_value($sformatf("state_o[%0d]", i), state_o, model_lane[i]);
    end
  endtask

  //////////////////////////////////////////////////
  // One pattern line
  //////////////////////////////////////////////////
  task automatic run_op(input string line);
    logic [7:0]       op;
    logic [WordW-1:0] a;
    logic [WordW-1:0] b;
    a  = '0;
    b  = '0;
    op = line.getc(0);
    void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
    case (op)
      "K": begin
        key_we_i   = 1'b1;
        key_idx_i  = a[KeyW-1:0];
        key_word_i = b;
        model_key[a[KeyW-1:0]] = b;
        tick();
      end
      "C": begin
        kmac_en_i = a[0];
        tick();
      end
      "W": send_word(a);
      "R": begin
        for (int i = 0; i < int'(a); i++) begin
          send_word($urandom());
        end
      end
      "S": begin
        issue_cmd(CmdStart);
        model_clear();
        // Key block fills a whole block, pointer wraps to lane 0
        if (kmac_en_i) begin
          for (int k = 0; k < `KMAC_KEY_WORDS; k++) begin
            model_lane[k] ^= model_key[k];
          end
        end
      end
      "P": begin
        // Key block must clear before Process is legal
        if (kmac_en_i) begin
          while (credit_total != words_sent) begin
            tick();
          end
          tick();
        end
        issue_cmd(CmdProcess);
        model_lane[model_ptr] ^= WordW'(6);
        model_lane[Lanes-1]   ^= {1'b1, {(WordW-1){1'b0}}};
      end
      "D": begin
        issue_cmd(CmdDone);
        model_clear();
        check_value("phase_o", phase_o, StIdle);
      end
      "A": begin
        while (!intr_done_o) begin
          tick();
        end
        check_value("phase_o", phase_o, StSqueeze);
        check_lanes();
      end
      "L": begin
        state_idx_i = lane_idx_t'(a);
        tick();
        check_value($sformatf("state_o[%0d]", a), state_o, b);
      end
      "E": begin
        issue_cmd(kmac_cmd_e'(a[1:0]));
        check_value("err_valid_o", err_valid_o, 1'b1);
        check_value("err_code_o", err_code_o, ErrSwCmdSequence);
        check_value("err_info_o", err_info_o, a[1:0]);
        check_value("intr_err_o", intr_err_o, 1'b1);
      end
      "F": begin
        check_value("msg_credit_o pulses", credit_total, words_sent);
        check_value("intr_fifo_empty_o", intr_fifo_empty_o, 1'b1);
      end
      "I": begin
        while (!idle_o) begin
          tick();
        end
        check_value("fifo_depth_o", fifo_depth_o, '0);
      end
      "Z": begin
        // Each selected interrupt is raised before its clear
        check_value("{intr_err_o, intr_fifo_empty_o, intr_done_o}",
                    {intr_err_o, intr_fifo_empty_o, intr_done_o} & a[2:0], a[2:0]);
        intr_clear_i = a[2:0];
        tick();
        check_value("{intr_err_o, intr_fifo_empty_o, intr_done_o}",
                    {intr_err_o, intr_fifo_empty_o, intr_done_o} & a[2:0], '0);
      end
      default: fail_run($sformatf("Unknown operation in pattern line: %s", line));
    endcase
  endtask

  initial begin
    int               fd;
    string            line;
    rst_ni       = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_i        = CmdNone;
    kmac_en_i    = 1'b0;
    key_we_i     = 1'b0;
    key_idx_i    = '0;
    key_word_i   = '0;
    msg_valid_i  = 1'b0;
    msg_data_i   = '0;
    state_idx_i  = '0;
    intr_clear_i = '0;
    credits      = `KMAC_FIFO_DEPTH;
    credit_total = 0;
    words_sent   = 0;
    cycles       = 0;
    model_clear();
    void'($urandom(32'h6478_1d44));

    fd = $fopen("kmac_patterns.txt", "r");
    if (fd == 0) begin
      fail_run("Could not open the pattern file kmac_patterns.txt");
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        ops.push_back(line);
      end
    end
    $fclose(fd);
    cycle_limit = 64 * ops.size() + 200;

    // Reset for 8 cycles, released on a falling edge
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    foreach (ops[i]) begin
      run_op(ops[i]);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* kmac_patterns.txt */
# op args in hex: K idx key | C kmac_en | W word | R count | S | P | D | A | F | I
# L lane expected | E illegal_cmd (expect error) | Z intr_clear_mask
C 0
E 2
S
W 00000011
W 00000022
W 00000033
E 3
P
A
L 0 00000011
L 3 80000006
D
I
L 0 00000000
Z 1
Z 2
Z 4
C 1
K 0 a5a50001
K 1 5a5a0002
S
L 0 00000000
W 00000100
P
A
L 0 a5a50101
L 1 5a5a0004
D
C 0
Z 3
S
R 0e
P
A
F
D
I

/* kmac.f */
+incdir+.
kmac_cmd_pkg.sv
sha3_pkg.sv
kmac_msgfifo.sv
kmac_core.sv
sha3_absorb.sv
kmac_ctrl.sv
kmac_top.sv
tb_clk_gen.sv
kmac_assert.sv
kmac_tb.sv

/* Makefile */
TOP = kmac_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f kmac.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
